// ==== keypad_lock.f ====
logic/lock_pkg.sv
logic/key_decoder.sv
logic/code_lock_fsm.sv
logic/lockout_timer.sv
logic/buzzer_tone.sv
logic/keypad_lock_top.sv
tests/keypad_lock_assert.sv
tests/keypad_lock_tb.sv

// ==== Makefile ====
TOP = keypad_lock_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f keypad_lock.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Simulation FAILED" sim.log; then exit 1; fi
	@grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only --timing -f keypad_lock.f --top-module $(TOP)
	verilator --lint-only -f keypad_lock.f --top-module keypad_lock_top

clean:
	rm -rf obj_dir sim.log

// ==== tests/keypad_lock_tb.sv ====
`timescale 1ns/1ps

module keypad_lock_tb;
    import lock_pkg::*;

    localparam int TIMEOUT_CYCLES = 20000;   // 60 ticks of 20 cycles plus key traffic

    typedef struct packed {
        logic [1:0]  mode;                   // 0 entry, 1 open, 2 lockout
        logic [11:0] digits;
        logic [1:0]  count;
        logic [2:0]  tries;
    } model_t;

    logic        clk;
    logic        rst;
    logic        tick_1hz;
    logic [15:0] onehot;
    logic [11:0] display;
    logic [2:0]  tries;
    logic        unlocked;
    logic        locked_out;
    logic        buzzer;

    model_t model;
    int     errors;
    int     cycles;
    int     lock_ticks;                      // ticks the timer has taken in lockout
    logic   locked_d;                        // locked_out one edge ago
    event   check_ev;

    keypad_lock_top DUT (
        .clk        (clk),
        .rst        (rst),
        .tick_1hz   (tick_1hz),
        .onehot     (onehot),
        .display    (display),
        .tries      (tries),
        .unlocked   (unlocked),
        .locked_out (locked_out),
        .buzzer     (buzzer)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        tick_1hz = 1'b0;
        forever begin
            repeat (19) @(negedge clk);
            tick_1hz = 1'b1;
            @(negedge clk);
            tick_1hz = 1'b0;
        end
    end

    // the timer loads on the first lockout edge, so a tick there is not a step
    always @(posedge clk) begin
        locked_d <= locked_out;
        if (!locked_out) begin
            lock_ticks <= 0;
        end else if (tick_1hz && locked_d) begin
            lock_ticks <= lock_ticks + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // expected state after one key event
    function automatic model_t ref_step(input model_t m, input key_kind_e kind,
                                        input logic [3:0] dig);
        model_t n;
        n = m;
        if (m.mode == 2'd0) begin
            case (kind)
                KIND_DIGIT: begin
                    if (m.count < 2'd3) begin
                        n.digits = {m.digits[7:0], dig};
                        n.count  = m.count + 2'd1;
                    end
                end
                KIND_ENTER: begin
                    if (m.count == 2'd3) begin
                        n.digits = '0;
                        n.count  = '0;
                        if (m.digits == SECRET_CODE) begin
                            n.mode = 2'd1;
                        end else begin
                            n.tries = m.tries + 3'd1;
                            if (n.tries == MAX_TRIES) n.mode = 2'd2;
                        end
                    end
                end
                KIND_CANCEL: begin
                    n.digits = '0;
                    n.count  = '0;
                end
                default: begin
                    n.digits = '0;
                    n.count  = '0;
                    n.tries  = '0;
                end
            endcase
        end else if (m.mode == 2'd1 && kind == KIND_CLEAR) begin
            n.mode  = 2'd0;
            n.tries = '0;
        end
        return n;
    endfunction

    function automatic logic [11:0] exp_display(input model_t m, input int ticks);
        int left;
        left = 60 - ticks;
        if (m.mode == 2'd1) return DISP_OPEN;
        if (m.mode == 2'd2) return {4'h0, 4'(left / 10), 4'(left % 10)};
        if (m.count == 2'd0) return DISP_BLANK;
        if (m.count == 2'd3) return m.digits;
        return {4'hF, m.digits[7:0]};
    endfunction

    function automatic logic decode_key(input logic [15:0] code, output key_kind_e kind,
                                        output logic [3:0] dig);
        kind = KIND_DIGIT;
        dig  = 4'd0;
        if (code == KEY_ENTER) kind = KIND_ENTER;
        else if (code == KEY_CLEAR) kind = KIND_CLEAR;
        else if (code == KEY_CANCEL) kind = KIND_CANCEL;
        else begin
            for (int i = 0; i < 10; i++) begin
                if (code == DIGIT_CODE[i]) begin
                    dig = 4'(i);
                    return 1'b1;
                end
            end
            return 1'b0;                     // zero, unmapped or multi-bit
        end
        return 1'b1;
    endfunction

    task automatic check_value(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        assert (exp == act) else begin
            errors++;
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // checks the outputs two cycles after each press
    initial begin
        forever begin
            @(check_ev);
            check_value("display", 16'(exp_display(model, lock_ticks)), 16'(display));
            check_value("tries", 16'(model.tries), 16'(tries));
            check_value("unlocked", 16'(model.mode == 2'd1), 16'(unlocked));
            check_value("locked_out", 16'(model.mode == 2'd2), 16'(locked_out));
        end
    end

    task automatic apply_key(input logic [15:0] code);
        key_kind_e kind;
        logic [3:0] dig;
        if (decode_key(code, kind, dig)) model = ref_step(model, kind, dig);
    endtask

    task automatic press(input logic [15:0] code);
        int hold;
        hold = 2 + int'($urandom % 4);
        @(negedge clk);
        onehot = code;
        apply_key(code);
        repeat (2) @(negedge clk);
        -> check_ev;
        repeat (hold - 2) @(negedge clk);
        onehot = 16'h0000;
        repeat (3) @(negedge clk);
    endtask

    task automatic wrong_code();
        logic [3:0] d [3];
        do begin
            for (int i = 0; i < 3; i++) d[i] = 4'($urandom % 10);
        end while ({d[0], d[1], d[2]} == SECRET_CODE);
        for (int i = 0; i < 3; i++) press(DIGIT_CODE[d[i]]);
    endtask

    // drives a key and counts buzzer rising edges until it falls quiet
    task automatic tone_check(input logic [15:0] code, output int rise_at, output int rises);
        int quiet;
        logic prev;
        rise_at = -1;
        rises   = 0;
        quiet   = 0;
        prev    = buzzer;
        @(negedge clk);
        onehot = code;
        apply_key(code);
        for (int c = 1; c < 400 && quiet < 40; c++) begin
            @(negedge clk);
            if (c == 2) -> check_ev;
            if (c == 3) onehot = 16'h0000;
            if (buzzer && !prev) begin
                rises++;
                if (rise_at < 0) rise_at = c;
            end
            quiet = (buzzer || rise_at < 0) ? 0 : quiet + 1;
            prev  = buzzer;
        end
    endtask

    task automatic gap_check();
        @(negedge clk);
        onehot = KEY_ENTER;
        apply_key(KEY_ENTER);
        for (int c = 1; c <= 70; c++) begin
            @(negedge clk);
            if (c == 2) -> check_ev;
            if (c == 3) onehot = 16'h0000;
            if (c >= 42 && c <= 56) check_value("buzzer", 16'h0000, 16'(buzzer));
        end
    endtask

    initial begin
        int rise_at;
        int key_rises;
        int ok_rises;
        void'($urandom(32'h09a0448d));
        errors = 0;
        rst    = 1'b1;
        onehot = 16'h0000;
        model  = '{mode: 2'd0, digits: 12'h000, count: 2'd0, tries: 3'd0};
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        -> check_ev;
        check_value("buzzer", 16'h0000, 16'(buzzer));

        // entry with the key tone measured on the first digit
        tone_check(DIGIT_CODE[2], rise_at, key_rises);
        assert (rise_at > 0 && rise_at <= 4) else begin
            errors++;
            $display("buzzer did not start within 4 cycles of a digit press");
        end
        assert (key_rises >= 3 && key_rises <= 5) else begin
            errors++;
            $display("key tone gave %0d rising edges instead of about 4", key_rises);
        end
        press(DIGIT_CODE[4]);
        press(DIGIT_CODE[6]);
        press(DIGIT_CODE[8]);                // fourth digit
        press(16'h0003);
        press(16'h0002);

        // correct code
        repeat (80) @(negedge clk);
        tone_check(KEY_ENTER, rise_at, ok_rises);
        assert (ok_rises > key_rises) else begin
            errors++;
            $display("success tone was not longer than the key tone");
        end
        press(DIGIT_CODE[1]);
        press(KEY_CLEAR);

        // wrong code, cancel and short enter
        wrong_code();
        press(KEY_ENTER);
        press(KEY_CANCEL);
        press(DIGIT_CODE[3]);
        press(DIGIT_CODE[5]);
        press(KEY_ENTER);
        press(KEY_CANCEL);
        wrong_code();
        repeat (80) @(negedge clk);
        gap_check();

        // lockout on the sixth failure
        while (model.mode != 2'd2) begin
            wrong_code();
            press(KEY_ENTER);
        end
        press(KEY_CLEAR);
        press(DIGIT_CODE[5]);
        while (lock_ticks < 60) begin
            @(negedge clk);
            -> check_ev;
        end
        @(negedge clk);                      // fsm leaves lockout one cycle after done
        model.mode  = 2'd0;
        model.tries = 3'd0;
        -> check_ev;
        repeat (5) @(negedge clk);

        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/keypad_lock_assert.sv ====
`timescale 1ns/1ps

module keypad_lock_assert (
    input logic        clk,
    input logic        rst,
    input logic [11:0] display,
    input logic [2:0]  tries,
    input logic        unlocked,
    input logic        locked_out
);
    import lock_pkg::*;

    open_xor_locked: assert property (@(posedge clk) disable iff (rst)
        !(unlocked && locked_out))
        else $error("unlocked and locked_out high together");

    tries_bounded: assert property (@(posedge clk) disable iff (rst)
        tries <= MAX_TRIES)
        else $error("tries above limit");

    // countdown shows 0 in the top glyph
    lockout_top_zero: assert property (@(posedge clk) disable iff (rst)
        locked_out |-> display[11:8] == 4'h0)
        else $error("display top nibble not 0 in lockout");

endmodule

bind keypad_lock_top keypad_lock_assert u_assert (
    .clk        (clk),
    .rst        (rst),
    .display    (display),
    .tries      (tries),
    .unlocked   (unlocked),
    .locked_out (locked_out)
);

// ==== logic/keypad_lock_top.sv ====
`timescale 1ns/1ps

module keypad_lock_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        tick_1hz,
    input  logic [15:0] onehot,
    output logic [11:0] display,
    output logic [2:0]  tries,
    output logic        unlocked,
    output logic        locked_out,
    output logic        buzzer
);
    import lock_pkg::*;

    key_evt_t    key_evt;
    tone_req_t   tone_req;
    logic        lockout_start;
    logic        lockout_done;
    logic [7:0]  secs_left;                  // bcd countdown

    key_decoder u_key_decoder (
        .clk     (clk),
        .rst     (rst),
        .onehot  (onehot),
        .key_evt (key_evt)
    );

    code_lock_fsm u_code_lock_fsm (
        .clk           (clk),
        .rst           (rst),
        .key_evt       (key_evt),
        .lockout_done  (lockout_done),
        .secs_left     (secs_left),
        .display       (display),
        .tries         (tries),
        .unlocked      (unlocked),
        .locked_out    (locked_out),
        .tone_req      (tone_req),
        .lockout_start (lockout_start)
    );

    lockout_timer u_lockout_timer (
        .clk           (clk),
        .rst           (rst),
        .tick_1hz      (tick_1hz),
        .lockout_start (lockout_start),
        .secs_left     (secs_left),
        .lockout_done  (lockout_done)
    );

    buzzer_tone u_buzzer_tone (
        .clk      (clk),
        .rst      (rst),
        .tone_req (tone_req),
        .buzzer   (buzzer)
    );

endmodule

// ==== logic/buzzer_tone.sv ====
`timescale 1ns/1ps

module buzzer_tone (
    input  logic                clk,
    input  logic                rst,
    input  lock_pkg::tone_req_t tone_req,
    output logic                buzzer
);
    import lock_pkg::*;

    tone_e       cur_pattern;                // latched on start
    logic        active;
    logic        phase;                      // square wave level
    logic [15:0] elapsed;
    logic [15:0] half_cnt;
    logic [15:0] half_len;
    logic [15:0] tone_len;
    logic        in_gap;

    always_comb begin
        case (cur_pattern)
            TONE_SUCCESS: begin
                half_len = TONE_OK_HALF;
                tone_len = TONE_OK_LEN;
            end
            TONE_FAIL: begin
                half_len = TONE_FAIL_HALF;
                tone_len = TONE_FAIL_LEN;
            end
            default: begin
                half_len = TONE_KEY_HALF;
                tone_len = TONE_KEY_LEN;
            end
        endcase
    end

    // silent stretch in the middle of the fail pattern
    assign in_gap = (cur_pattern == TONE_FAIL) &&
                    (elapsed >= TONE_FAIL_GAP_LO) && (elapsed < TONE_FAIL_GAP_HI);

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            phase  <= 1'b0;
        end else if (tone_req.start) begin
            active <= 1'b1;                  // newer request restarts
            phase  <= 1'b1;
        end else if (active) begin
            if (elapsed == tone_len - 16'd1) begin
                active <= 1'b0;
                phase  <= 1'b0;
            end else if (half_cnt == half_len - 16'd1) begin
                phase <= ~phase;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tone_req.start) begin
            cur_pattern <= tone_req.pattern;
            elapsed     <= '0;
            half_cnt    <= '0;
        end else if (active) begin
            elapsed <= elapsed + 16'd1;
            if (half_cnt == half_len - 16'd1) begin
                half_cnt <= '0;
            end else begin
                half_cnt <= half_cnt + 16'd1;
            end
        end
    end

    assign buzzer = active && phase && !in_gap;

endmodule

// ==== logic/lockout_timer.sv ====
`timescale 1ns/1ps

module lockout_timer (
    input  logic       clk,
    input  logic       rst,
    input  logic       tick_1hz,
    input  logic       lockout_start,
    output logic [7:0] secs_left,
    output logic       lockout_done
);
    import lock_pkg::*;

    logic running;

    always_ff @(posedge clk) begin
        if (rst) begin
            running      <= 1'b0;
            secs_left    <= 8'h00;
            lockout_done <= 1'b0;
        end else begin
            lockout_done <= 1'b0;
            if (lockout_start) begin
                secs_left <= LOCKOUT_SECS;       // reload wins over a tick
                running   <= 1'b1;
            end else if (running && tick_1hz) begin
                if (secs_left == 8'h01) begin
                    secs_left    <= 8'h00;       // last second so stop here
                    running      <= 1'b0;
                    lockout_done <= 1'b1;
                end else if (secs_left[3:0] == 4'h0) begin
                    // borrow from tens
                    secs_left[7:4] <= secs_left[7:4] - 4'h1;
                    secs_left[3:0] <= 4'h9;
                end else begin
                    secs_left[3:0] <= secs_left[3:0] - 4'h1;
                end
            end
        end
    end

endmodule

// ==== logic/code_lock_fsm.sv ====
`timescale 1ns/1ps

module code_lock_fsm (
    input  logic                clk,
    input  logic                rst,
    input  lock_pkg::key_evt_t  key_evt,
    input  logic                lockout_done,
    input  logic [7:0]          secs_left,
    output logic [11:0]         display,
    output logic [2:0]          tries,
    output logic                unlocked,
    output logic                locked_out,
    output lock_pkg::tone_req_t tone_req,
    output logic                lockout_start
);
    import lock_pkg::*;

    typedef enum logic [1:0] {
        ST_ENTRY,
        ST_OPEN,
        ST_LOCKOUT
    } state_e;

    state_e      state;
    logic [11:0] digits;                     // entered digits, right aligned
    logic [1:0]  count;                      // how many digits are in
    logic [2:0]  tries_inc;
    logic        code_ok;

    assign tries_inc = tries + 3'd1;
    assign code_ok   = (digits == SECRET_CODE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= ST_ENTRY;
            digits         <= '0;
            count          <= '0;
            tries          <= '0;
            tone_req.start <= 1'b0;
            lockout_start  <= 1'b0;
        end else begin
            tone_req.start <= 1'b0;
            lockout_start  <= 1'b0;
            case (state)
                ST_ENTRY: begin
                    if (key_evt.valid) begin
                        case (key_evt.kind)
                            KIND_DIGIT: begin
                                if (count != 2'd3) begin   // fourth digit dropped
                                    digits           <= {digits[7:0], key_evt.digit};
                                    count            <= count + 2'd1;
                                    tone_req.start   <= 1'b1;
                                    tone_req.pattern <= TONE_KEY;
                                end
                            end
                            KIND_ENTER: begin
                                if (count == 2'd3) begin   // short entry ignored
                                    digits         <= '0;
                                    count          <= '0;
                                    tone_req.start <= 1'b1;
                                    if (code_ok) begin
                                        state            <= ST_OPEN;
                                        tone_req.pattern <= TONE_SUCCESS;
                                    end else begin
                                        tries            <= tries_inc;
                                        tone_req.pattern <= TONE_FAIL;
                                        if (tries_inc == MAX_TRIES) begin
                                            state         <= ST_LOCKOUT;
                                            lockout_start <= 1'b1;
                                        end
                                    end
                                end
                            end
                            KIND_CANCEL: begin
                                digits           <= '0;
                                count            <= '0;
                                tone_req.start   <= 1'b1;
                                tone_req.pattern <= TONE_KEY;
                            end
                            default: begin         // clear
                                digits           <= '0;
                                count            <= '0;
                                tries            <= '0;
                                tone_req.start   <= 1'b1;
                                tone_req.pattern <= TONE_KEY;
                            end
                        endcase
                    end
                end
                ST_OPEN: begin
                    // only clear relocks
                    if (key_evt.valid && key_evt.kind == KIND_CLEAR) begin
                        state            <= ST_ENTRY;
                        tries            <= '0;
                        tone_req.start   <= 1'b1;
                        tone_req.pattern <= TONE_KEY;
                    end
                end
                ST_LOCKOUT: begin
                    if (lockout_done) begin        // keys ignored until here
                        state <= ST_ENTRY;
                        tries <= '0;
                    end
                end
                default: state <= ST_ENTRY;
            endcase
        end
    end

    always_comb begin
        case (state)
            ST_OPEN: display = DISP_OPEN;
            ST_LOCKOUT: begin
                // timer loads on lockout_start so show the full count meanwhile
                if (lockout_start) begin
                    display = {4'h0, LOCKOUT_SECS};
                end else begin
                    display = {4'h0, secs_left};
                end
            end
            default: begin
                case (count)
                    2'd0:    display = DISP_BLANK;
                    2'd3:    display = digits;
                    default: display = {4'hF, digits[7:0]};
                endcase
            end
        endcase
    end

    assign unlocked   = (state == ST_OPEN);
    assign locked_out = (state == ST_LOCKOUT);

endmodule

// ==== logic/key_decoder.sv ====
`timescale 1ns/1ps

module key_decoder (
    input  logic               clk,
    input  logic               rst,
    input  logic [15:0]        onehot,
    output lock_pkg::key_evt_t key_evt
);
    import lock_pkg::*;

    logic [15:0] prev_onehot;                // keypad value seen last cycle
    logic        dec_hit;
    key_kind_e   dec_kind;
    logic [3:0]  dec_digit;

    // map the raw keypad word onto a key kind and digit
    always_comb begin
        dec_hit   = 1'b1;
        dec_kind  = KIND_DIGIT;
        dec_digit = 4'd0;
        case (onehot)
            KEY_ENTER:  dec_kind = KIND_ENTER;
            KEY_CLEAR:  dec_kind = KIND_CLEAR;
            KEY_CANCEL: dec_kind = KIND_CANCEL;
            default: begin
                dec_hit = 1'b0;              // zero, unmapped or multi-bit
                for (int i = 0; i < 10; i++) begin
                    if (onehot == DIGIT_CODE[i]) begin
                        dec_hit   = 1'b1;
                        dec_digit = 4'(i);
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prev_onehot   <= '0;
            key_evt.valid <= 1'b0;
        end else begin
            prev_onehot   <= onehot;
            // a held key matches prev_onehot so only new presses fire
            key_evt.valid <= dec_hit && (onehot != prev_onehot);
        end
    end

    // kind and digit ride along with the strobe
    always_ff @(posedge clk) begin
        key_evt.kind  <= dec_kind;
        key_evt.digit <= dec_digit;
    end

endmodule

// ==== logic/lock_pkg.sv ====
package lock_pkg;

    typedef enum logic [1:0] {
        KIND_DIGIT,
        KIND_ENTER,
        KIND_CLEAR,
        KIND_CANCEL
    } key_kind_e;

    typedef struct packed {
        logic      valid;                    // one-cycle press strobe
        key_kind_e kind;
        logic [3:0] digit;                   // only meaningful for digit keys
    } key_evt_t;

    typedef enum logic [1:0] {
        TONE_KEY,
        TONE_SUCCESS,
        TONE_FAIL
    } tone_e;

    typedef struct packed {
        logic  start;                        // restarts the generator
        tone_e pattern;
    } tone_req_t;

    // keypad one-hot codes
    localparam logic [15:0] KEY_ENTER  = 16'h0001;
    localparam logic [15:0] KEY_CLEAR  = 16'h0100;
    localparam logic [15:0] KEY_CANCEL = 16'h1000;

    // digit key lookup indexed by digit value
    localparam logic [15:0] DIGIT_CODE [10] = '{
        16'h0008, 16'h0080, 16'h0040, 16'h0020, 16'h0800,
        16'h0400, 16'h0200, 16'h8000, 16'h4000, 16'h2000
    };

    localparam logic [11:0] DISP_BLANK  = 12'hFFF;
    localparam logic [11:0] DISP_OPEN   = 12'hBCC;   // "ASS" glyphs
    localparam logic [11:0] SECRET_CODE = 12'h246;

    localparam logic [2:0] MAX_TRIES    = 3'd6;
    localparam logic [7:0] LOCKOUT_SECS = 8'h60;     // bcd

    // tone timing in clk cycles scaled down for simulation
    localparam logic [15:0] TONE_KEY_HALF    = 16'd8;
    localparam logic [15:0] TONE_KEY_LEN     = 16'd64;
    localparam logic [15:0] TONE_OK_HALF     = 16'd4;
    localparam logic [15:0] TONE_OK_LEN      = 16'd192;
    localparam logic [15:0] TONE_FAIL_HALF   = 16'd16;
    localparam logic [15:0] TONE_FAIL_LEN    = 16'd96;
    localparam logic [15:0] TONE_FAIL_GAP_LO = 16'd32;
    localparam logic [15:0] TONE_FAIL_GAP_HI = 16'd64;

endpackage
